// ==== Makefile ====
# Verilator flow for the global control block

TOP = tb_gc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/gc_assertions.sv ====
// Global control protocol assertions
module gc_assertions (
    input logic               clk,
    input logic               rst,
    input logic               idle,
    input logic               br_valid,
    input logic               ls_valid,
    input logic               redirect_valid,
    input gc_pkg::wb_result_t wb,
    input logic               wb_valid,
    input logic               wb_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    // Exception reports only while the controller is idle
    exc_only_in_idle: assert property (
        @(posedge clk) disable iff (rst) (br_valid || ls_valid) |-> idle
    ) else $error("exception report outside IDLE");

    // Redirect is a single-cycle pulse
    redirect_single_pulse: assert property (
        @(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid
    ) else $error("redirect_valid high for two cycles");

    // Result held while write-back stalls
    wb_stable_on_stall: assert property (
        @(posedge clk) disable iff (rst) (wb_valid && !wb_ready) |=> $stable(wb)
    ) else $error("wb changed while stalled");

endmodule

bind gc_unit gc_assertions gc_assertions_i (
    .clk            (clk),
    .rst            (rst),
    .idle           (state == IDLE),
    .br_valid       (br_exc.valid),
    .ls_valid       (ls_exc.valid),
    .redirect_valid (redirect_valid),
    .wb             (wb),
    .wb_valid       (wb_valid),
    .wb_ready       (wb_ready)
);

// ==== bench/tb_clock.sv ====
// Testbench clock and reset
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== bench/tb_gc.sv ====
// Global control testbench
module tb_gc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLEAR_DEPTH = 8;
    localparam int TIMEOUT     = 64;
    localparam gc_pkg::xlen_t MTVEC = 32'h0000_0100;

    typedef enum {KIND_REQ, KIND_BR, KIND_LS, KIND_BR_LS} kind_t;

    // One stimulus row
    // Operand carries the cause code in exception rows
    typedef struct {
        string             name;
        kind_t             kind;
        gc_pkg::gc_op_t    op;
        gc_pkg::csr_addr_t addr;
        gc_pkg::xlen_t     operand;
        gc_pkg::xlen_t     pc;
        gc_pkg::xlen_t     instr;
        bit                check_data;
        gc_pkg::xlen_t     expected;
    } row_t;

    logic                clk;
    logic                rst;
    gc_pkg::gc_req_t     req;
    logic                req_valid;
    logic                req_ready;
    gc_pkg::exc_packet_t br_exc;
    gc_pkg::exc_packet_t ls_exc;
    logic                ls_idle;
    logic                retire;
    logic                fetch_hold;
    logic                init_clear;
    logic                issue_hold;
    logic                fetch_flush;
    logic                redirect_valid;
    gc_pkg::xlen_t       redirect_pc;
    gc_pkg::wb_result_t  wb;
    logic                wb_valid;
    logic                wb_ready;

    row_t          rows[$];
    logic [31:0]   lfsr_q = 32'h82aea780;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    gc_top #(
        .CLEAR_DEPTH (CLEAR_DEPTH),
        .MTVEC_RESET (MTVEC)
    ) gc_top_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .br_exc         (br_exc),
        .ls_exc         (ls_exc),
        .ls_idle        (ls_idle),
        .retire         (retire),
        .fetch_hold     (fetch_hold),
        .init_clear     (init_clear),
        .issue_hold     (issue_hold),
        .fetch_flush    (fetch_flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb             (wb),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    task automatic tick();
        @(negedge clk);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_xlen(input string name, input gc_pkg::xlen_t exp,
                              input gc_pkg::xlen_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_id(input string name, input gc_pkg::id_t exp,
                            input gc_pkg::id_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Fibonacci LFSR stepped once per bit taken
    // Taps at 32 22 2 1
    function automatic int take_bits(input int n);
        logic fb;
        int   value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            value  = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // Implemented machine CSRs
    function automatic bit csr_known(input gc_pkg::csr_addr_t a);
        return a inside {gc_pkg::CSR_MSTATUS, gc_pkg::CSR_MTVEC, gc_pkg::CSR_MSCRATCH,
                         gc_pkg::CSR_MEPC, gc_pkg::CSR_MCAUSE, gc_pkg::CSR_MTVAL,
                         gc_pkg::CSR_MINSTRET};
    endfunction

    task automatic add_row(input string name, input kind_t kind, input gc_pkg::gc_op_t op,
                           input gc_pkg::csr_addr_t addr, input gc_pkg::xlen_t operand,
                           input gc_pkg::xlen_t pc, input gc_pkg::xlen_t instr,
                           input bit check_data, input gc_pkg::xlen_t expected);
        row_t r;
        r = '{name, kind, op, addr, operand, pc, instr, check_data, expected};
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-row sequence
    task automatic run_row(input row_t r, input gc_pkg::id_t id);
        int  n;
        int  drain;
        int  stall;
        bit  drain_op;
        bit  to_wb;
        drain_op = (r.kind == KIND_REQ) && (r.op inside {gc_pkg::OP_CSRRW, gc_pkg::OP_CSRRS,
                                                          gc_pkg::OP_CSRRC, gc_pkg::OP_FENCE_I});
        to_wb    = drain_op && r.op != gc_pkg::OP_FENCE_I && csr_known(r.addr);
        // ls_idle held low for 1 to 8 cycles
        drain    = take_bits(3) + 1;
        stall    = take_bits(2);
        n = 0;
        while (!req_ready) begin
            tick();
            n++;
            if (n > TIMEOUT) report_failure({r.name, ": controller never became ready"});
        end
        // Drive the event for one cycle
        if (r.kind == KIND_REQ) begin
            req       = '{r.op, id, r.pc, r.addr, r.operand, r.instr};
            req_valid = 1'b1;
            if (drain_op) ls_idle = 1'b0;
        end
        if (r.kind inside {KIND_BR, KIND_BR_LS}) begin
            br_exc = '{1'b1, r.operand[3:0], r.instr, r.pc, id};
        end
        if (r.kind == KIND_LS) begin
            ls_exc = '{1'b1, r.operand[3:0], r.instr, r.pc, id};
        end
        if (r.kind == KIND_BR_LS) begin
            ls_exc = '{1'b1, gc_pkg::EXC_LOAD_MISALIGNED, 32'd0, r.pc + 32'h100, id};
        end
        tick();
        req_valid = 1'b0;
        br_exc    = '0;
        ls_exc    = '0;
        if (!drain_op) begin
            // Flush at T+1 and redirect at T+2
            check_xlen({r.name, " fetch_flush"}, 32'd1, {31'd0, fetch_flush});
            tick();
            check_xlen({r.name, " redirect_valid"}, 32'd1, {31'd0, redirect_valid});
            check_xlen({r.name, " redirect_pc"}, r.expected, redirect_pc);
        end else begin
            // Nothing may complete while the queue is busy
            for (int i = 0; i < drain; i++) begin
                tick();
                if (redirect_valid || wb_valid || fetch_flush) begin
                    report_failure({r.name, ": completed before ls_idle was seen"});
                end
                if (!issue_hold) report_failure({r.name, ": issue_hold low while draining"});
            end
            ls_idle = 1'b1;
            if (to_wb) begin
                n = 0;
                while (!wb_valid) begin
                    tick();
                    n++;
                    if (n > TIMEOUT) report_failure({r.name, ": no write-back"});
                end
                // Back-pressure keeps the result up and issue closed
                for (int i = 0; i < stall; i++) begin
                    tick();
                    if (!wb_valid || req_ready) begin
                        report_failure({r.name, ": write-back not held under stall"});
                    end
                end
                check_id({r.name, " wb id"}, id, wb.id);
                if (r.check_data) check_xlen({r.name, " wb data"}, r.expected, wb.data);
                wb_ready = 1'b1;
                tick();
                wb_ready = 1'b0;
            end else begin
                n = 0;
                while (!fetch_flush) begin
                    tick();
                    n++;
                    if (n > TIMEOUT) report_failure({r.name, ": no flush"});
                end
                tick();
                check_xlen({r.name, " redirect_valid"}, 32'd1, {31'd0, redirect_valid});
                check_xlen({r.name, " redirect_pc"}, r.expected, redirect_pc);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    task automatic build_table();
        // CSR read-modify-write on mscratch
        add_row("scratch_init", KIND_REQ, gc_pkg::OP_CSRRW, gc_pkg::CSR_MSCRATCH,
                32'hA5A5_0F0F, 32'h1000, 32'h3400_1073, 1'b0, 32'd0);
        add_row("scratch_set", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MSCRATCH,
                32'h0000_F0F0, 32'h1004, 32'h3400_2073, 1'b1, 32'hA5A5_0F0F);
        add_row("scratch_clear", KIND_REQ, gc_pkg::OP_CSRRC, gc_pkg::CSR_MSCRATCH,
                32'hFFFF_0000, 32'h1008, 32'h3400_3073, 1'b1, 32'hA5A5_FFFF);
        add_row("scratch_read", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MSCRATCH,
                32'd0, 32'h100C, 32'h3400_2073, 1'b1, 32'h0000_FFFF);
        // ECALL and EBREAK
        add_row("ecall", KIND_REQ, gc_pkg::OP_ECALL, 12'h000, 32'd0,
                32'h2000, 32'h0000_0073, 1'b1, MTVEC);
        add_row("ecall_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'd11);
        add_row("ecall_mepc", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MEPC,
                32'd0, 32'h0104, 32'd0, 1'b1, 32'h2000);
        add_row("ebreak", KIND_REQ, gc_pkg::OP_EBREAK, 12'h000, 32'd0,
                32'h2040, 32'h0010_0073, 1'b1, MTVEC);
        add_row("ebreak_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'd3);
        add_row("ebreak_mepc", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MEPC,
                32'd0, 32'h0104, 32'd0, 1'b1, 32'h2040);
        // Illegal handling
        add_row("csr_unknown", KIND_REQ, gc_pkg::OP_CSRRW, 12'h7C0, 32'h1234_5678,
                32'h2060, 32'h7C00_1073, 1'b1, MTVEC);
        add_row("unknown_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'd2);
        add_row("unknown_mtval", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MTVAL,
                32'd0, 32'h0104, 32'd0, 1'b1, 32'h7C00_1073);
        add_row("op_illegal", KIND_REQ, gc_pkg::OP_ILLEGAL, 12'h000, 32'd0,
                32'h2080, 32'hFFFF_FFFF, 1'b1, MTVEC);
        add_row("illegal_mtval", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MTVAL,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'hFFFF_FFFF);
        add_row("illegal_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0104, 32'd0, 1'b1, 32'd2);
        // Branch beats load/store in the same cycle
        add_row("br_and_ls", KIND_BR_LS, gc_pkg::OP_CSRRW, 12'h000,
                32'(gc_pkg::EXC_INST_MISALIGNED), 32'h3000, 32'h0000_3002, 1'b1, MTVEC);
        add_row("br_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'(gc_pkg::EXC_INST_MISALIGNED));
        add_row("br_mepc", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MEPC,
                32'd0, 32'h0104, 32'd0, 1'b1, 32'h3000);
        add_row("ls_alone", KIND_LS, gc_pkg::OP_CSRRW, 12'h000,
                32'(gc_pkg::EXC_LOAD_MISALIGNED), 32'h3200, 32'h0000_8001, 1'b1, MTVEC);
        add_row("ls_mcause", KIND_REQ, gc_pkg::OP_CSRRS, gc_pkg::CSR_MCAUSE,
                32'd0, 32'h0100, 32'd0, 1'b1, 32'(gc_pkg::EXC_LOAD_MISALIGNED));
        // MRET and FENCE.I
        add_row("mepc_write", KIND_REQ, gc_pkg::OP_CSRRW, gc_pkg::CSR_MEPC,
                32'h0000_4000, 32'h0104, 32'd0, 1'b1, 32'h3200);
        add_row("mret", KIND_REQ, gc_pkg::OP_MRET, 12'h000, 32'd0,
                32'h0108, 32'h3020_0073, 1'b1, 32'h0000_4000);
        add_row("fence_i", KIND_REQ, gc_pkg::OP_FENCE_I, 12'h000, 32'd0,
                32'h5000, 32'h0000_100F, 1'b1, 32'h0000_5004);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int n;
        int clear_cycles;
        req       = '0;
        req_valid = 1'b0;
        br_exc    = '0;
        ls_exc    = '0;
        ls_idle   = 1'b1;
        retire    = 1'b0;
        wb_ready  = 1'b0;
        build_table();

        // Reset and clearing phase
        n = 0;
        while (init_clear !== 1'b1) begin
            tick();
            n++;
            if (req_ready || redirect_valid || fetch_flush || wb_valid) begin
                report_failure("handshake or redirect output high before the clearing phase");
            end
            if (n > TIMEOUT) report_failure("init_clear never rose");
        end
        clear_cycles = 0;
        while (init_clear) begin
            if (!fetch_hold) report_failure("fetch_hold low during init_clear");
            if (!issue_hold) report_failure("issue_hold low during init_clear");
            clear_cycles++;
            tick();
            if (clear_cycles > TIMEOUT) report_failure("init_clear never fell");
        end
        check_xlen("init_clear_length", CLEAR_DEPTH, clear_cycles);
        n = 0;
        while (!req_ready) begin
            tick();
            n++;
            if (n > TIMEOUT) report_failure("req_ready never rose after reset");
        end
        if (fetch_hold) report_failure("req_ready rose while fetch_hold was high");
        if (issue_hold) report_failure("req_ready rose while issue_hold was high");

        foreach (rows[i]) begin
            run_row(rows[i], i[2:0]);
        end

        tick();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/gc_pkg.sv
rtl/clear_counter.sv
rtl/csr_regs.sv
rtl/gc_unit.sv
rtl/gc_top.sv
bench/tb_clock.sv
bench/gc_assertions.sv
bench/tb_gc.sv

// ==== rtl/clear_counter.sv ====
// One-hot clear phase counter
module clear_counter #(
    parameter int DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    // Single token walks from bit 0 to the top bit
    logic [DEPTH-1:0] shift_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_q <= '0;
        end else begin
            shift_q <= {shift_q[DEPTH-2:0], start};
        end
    end

    // Top bit set on the DEPTH-th cycle after start
    assign done = shift_q[DEPTH-1];

endmodule

// ==== rtl/csr_regs.sv ====
// Machine-mode CSR file
module csr_regs #(
    parameter gc_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic               clk,
    input  logic               rst,
    input  gc_pkg::trap_info_t trap,
    input  logic               csr_start,
    input  gc_pkg::gc_op_t     csr_op,
    input  gc_pkg::csr_addr_t  csr_addr,
    input  gc_pkg::xlen_t      csr_operand,
    input  logic               retire,
    output gc_pkg::xlen_t      csr_rdata,
    output logic               csr_illegal,
    output gc_pkg::xlen_t      mtvec,
    output gc_pkg::xlen_t      mepc
);

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    // mstatus keeps only MIE (bit 3) and MPIE (bit 7)
    logic              mie_q;
    logic              mpie_q;
    logic [31:2]       mtvec_q;
    gc_pkg::xlen_t     mscratch_q;
    gc_pkg::xlen_t     mepc_q;
    gc_pkg::exc_code_t mcause_q;
    gc_pkg::xlen_t     mtval_q;
    gc_pkg::xlen_t     minstret_q;

    gc_pkg::xlen_t     wdata;
    logic              csr_we;

    ////////////////////////////////////////////////////////////////////////////
    // Read port and address decode
    always_comb begin
        csr_rdata   = '0;
        csr_illegal = 1'b0;
        case (csr_addr)
            gc_pkg::CSR_MSTATUS: begin
                csr_rdata[3] = mie_q;
                csr_rdata[7] = mpie_q;
            end
            gc_pkg::CSR_MTVEC:    csr_rdata = {mtvec_q, 2'b00};
            gc_pkg::CSR_MSCRATCH: csr_rdata = mscratch_q;
            gc_pkg::CSR_MEPC:     csr_rdata = mepc_q;
            gc_pkg::CSR_MCAUSE:   csr_rdata = {28'd0, mcause_q};
            gc_pkg::CSR_MTVAL:    csr_rdata = mtval_q;
            gc_pkg::CSR_MINSTRET: csr_rdata = minstret_q;
            // Unknown address, caller raises illegal
            default:              csr_illegal = 1'b1;
        endcase
    end

    // Read-modify-write value
    always_comb begin
        case (csr_op)
            gc_pkg::OP_CSRRW: wdata = csr_operand;
            gc_pkg::OP_CSRRS: wdata = csr_rdata | csr_operand;
            gc_pkg::OP_CSRRC: wdata = csr_rdata & ~csr_operand;
            default:          wdata = csr_rdata;
        endcase
    end

    // No write on an unknown address
    assign csr_we = csr_start & ~csr_illegal;

    ////////////////////////////////////////////////////////////////////////////
    // mstatus
    // Trap stacks MIE into MPIE, MRET pops it back
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap.take_trap) begin
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (trap.mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (csr_we && csr_addr == gc_pkg::CSR_MSTATUS) begin
            mie_q  <= wdata[3];
            mpie_q <= wdata[7];
        end
    end

    // mtvec, direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_q <= MTVEC_RESET[31:2];
        end else if (csr_we && csr_addr == gc_pkg::CSR_MTVEC) begin
            mtvec_q <= wdata[31:2];
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_addr == gc_pkg::CSR_MSCRATCH) begin
            mscratch_q <= wdata;
        end
    end

    // Trap record
    always_ff @(posedge clk) begin
        if (trap.take_trap) begin
            mepc_q   <= trap.pc;
            mcause_q <= trap.code;
            mtval_q  <= trap.tval;
        end else if (csr_we) begin
            if (csr_addr == gc_pkg::CSR_MEPC) begin
                mepc_q <= {wdata[31:2], 2'b00};
            end
            if (csr_addr == gc_pkg::CSR_MCAUSE) begin
                mcause_q <= wdata[3:0];
            end
            if (csr_addr == gc_pkg::CSR_MTVAL) begin
                mtval_q <= wdata;
            end
        end
    end

    // Retired instruction count, writes ignored
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_q <= '0;
        end else if (retire) begin
            minstret_q <= minstret_q + 32'd1;
        end
    end

    assign mtvec = {mtvec_q, 2'b00};
    assign mepc  = mepc_q;

endmodule

// ==== rtl/gc_pkg.sv ====
// Global control shared definitions
package gc_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    typedef logic [31:0] xlen_t;
    typedef logic [2:0]  id_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  exc_code_t;

    // Machine cause codes
    localparam exc_code_t EXC_INST_MISALIGNED  = 4'd0;
    localparam exc_code_t EXC_ILLEGAL          = 4'd2;
    localparam exc_code_t EXC_BREAK            = 4'd3;
    localparam exc_code_t EXC_LOAD_MISALIGNED  = 4'd4;
    localparam exc_code_t EXC_STORE_MISALIGNED = 4'd6;
    localparam exc_code_t EXC_ECALL_M          = 4'd11;

    // System operations accepted from issue
    typedef enum logic [2:0] {
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET,
        OP_FENCE_I,
        OP_ILLEGAL
    } gc_op_t;

    // Machine-mode CSR map
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MINSTRET = 12'hB02;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    typedef struct packed {
        gc_op_t    op;
        id_t       id;
        xlen_t     pc;
        csr_addr_t csr_addr;
        xlen_t     operand;
        // Raw word, becomes mtval on illegal
        xlen_t     instr;
    } gc_req_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        xlen_t     tval;
        xlen_t     pc;
        id_t       id;
    } exc_packet_t;

    typedef struct packed {
        id_t   id;
        xlen_t data;
    } wb_result_t;

    typedef struct packed {
        logic      take_trap;
        logic      mret;
        exc_code_t code;
        xlen_t     tval;
        xlen_t     pc;
    } trap_info_t;

endpackage

// ==== rtl/gc_top.sv ====
// Global control top level
module gc_top #(
    parameter int            CLEAR_DEPTH = 8,
    parameter gc_pkg::xlen_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                rst,
    input  gc_pkg::gc_req_t     req,
    input  logic                req_valid,
    output logic                req_ready,
    input  gc_pkg::exc_packet_t br_exc,
    input  gc_pkg::exc_packet_t ls_exc,
    input  logic                ls_idle,
    input  logic                retire,
    output logic                fetch_hold,
    output logic                init_clear,
    output logic                issue_hold,
    output logic                fetch_flush,
    output logic                redirect_valid,
    output gc_pkg::xlen_t       redirect_pc,
    output gc_pkg::wb_result_t  wb,
    output logic                wb_valid,
    input  logic                wb_ready
);

    // Controller to CSR file
    gc_pkg::trap_info_t trap;
    logic               csr_start;
    gc_pkg::gc_op_t     csr_op;
    gc_pkg::csr_addr_t  csr_addr;
    gc_pkg::xlen_t      csr_operand;
    // CSR file back to controller
    gc_pkg::xlen_t      csr_rdata;
    logic               csr_illegal;
    gc_pkg::xlen_t      mtvec;
    gc_pkg::xlen_t      mepc;
    // Clear phase counter
    logic               clear_start;
    logic               clear_done;

    gc_unit #(
        .CLEAR_DEPTH (CLEAR_DEPTH)
    ) gc_unit_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .br_exc         (br_exc),
        .ls_exc         (ls_exc),
        .ls_idle        (ls_idle),
        .clear_start    (clear_start),
        .clear_done     (clear_done),
        .trap           (trap),
        .csr_start      (csr_start),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_operand    (csr_operand),
        .csr_rdata      (csr_rdata),
        .csr_illegal    (csr_illegal),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .fetch_hold     (fetch_hold),
        .init_clear     (init_clear),
        .issue_hold     (issue_hold),
        .fetch_flush    (fetch_flush),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb             (wb),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready)
    );

    csr_regs #(
        .MTVEC_RESET (MTVEC_RESET)
    ) csr_regs_i (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .csr_start   (csr_start),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_operand (csr_operand),
        .retire      (retire),
        .csr_rdata   (csr_rdata),
        .csr_illegal (csr_illegal),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    clear_counter #(
        .DEPTH (CLEAR_DEPTH)
    ) init_clear_counter (
        .clk   (clk),
        .rst   (rst),
        .start (clear_start),
        .done  (clear_done)
    );

endmodule

// ==== rtl/gc_unit.sv ====
// Global control state machine
module gc_unit #(
    parameter int CLEAR_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  gc_pkg::gc_req_t     req,
    input  logic                req_valid,
    output logic                req_ready,
    input  gc_pkg::exc_packet_t br_exc,
    input  gc_pkg::exc_packet_t ls_exc,
    input  logic                ls_idle,
    output logic                clear_start,
    input  logic                clear_done,
    output gc_pkg::trap_info_t  trap,
    output logic                csr_start,
    output gc_pkg::gc_op_t      csr_op,
    output gc_pkg::csr_addr_t   csr_addr,
    output gc_pkg::xlen_t       csr_operand,
    input  gc_pkg::xlen_t       csr_rdata,
    input  logic                csr_illegal,
    input  gc_pkg::xlen_t       mtvec,
    input  gc_pkg::xlen_t       mepc,
    output logic                fetch_hold,
    output logic                init_clear,
    output logic                issue_hold,
    output logic                fetch_flush,
    output logic                redirect_valid,
    output gc_pkg::xlen_t       redirect_pc,
    output gc_pkg::wb_result_t  wb,
    output logic                wb_valid,
    input  logic                wb_ready
);

    typedef enum logic [2:0] {
        RESET,
        PRE_CLEAR,
        INIT_CLEAR,
        IDLE,
        DRAIN,
        FLUSH,
        REDIRECT,
        WB_WAIT
    } gc_state_t;

    gc_state_t          state;
    gc_state_t          next_state;
    gc_pkg::gc_req_t    stage_q;
    gc_pkg::trap_info_t trap_d;
    gc_pkg::trap_info_t trap_q;
    gc_pkg::xlen_t      redirect_pc_q;
    gc_pkg::wb_result_t wb_q;
    logic               accept;
    logic               stage_is_csr;

    // clear_counter needs at least two bits to shift
    if (CLEAR_DEPTH < 2) begin : g_depth_check
        $error("CLEAR_DEPTH must be at least 2");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue handshake
    // Only take requests when idle and no unit reports an exception
    assign req_ready = (state == IDLE) & ~br_exc.valid & ~ls_exc.valid;
    assign accept    = req_valid & req_ready;

    // Request held here while the load/store queue drains
    always_ff @(posedge clk) begin
        if (accept) begin
            stage_q <= req;
        end
    end

    assign stage_is_csr = stage_q.op inside {gc_pkg::OP_CSRRW, gc_pkg::OP_CSRRS,
                                             gc_pkg::OP_CSRRC};

    ////////////////////////////////////////////////////////////////////////////
    // Exception selection
    // Priority is branch, illegal op, load/store, ECALL, EBREAK
    always_comb begin
        trap_d = '0;
        if (state == IDLE) begin
            if (br_exc.valid) begin
                trap_d.take_trap = 1'b1;
                trap_d.code      = br_exc.code;
                trap_d.tval      = br_exc.tval;
                trap_d.pc        = br_exc.pc;
            end else if (accept && req.op == gc_pkg::OP_ILLEGAL) begin
                trap_d.take_trap = 1'b1;
                trap_d.code      = gc_pkg::EXC_ILLEGAL;
                trap_d.tval      = req.instr;
                trap_d.pc        = req.pc;
            end else if (ls_exc.valid) begin
                trap_d.take_trap = 1'b1;
                trap_d.code      = ls_exc.code;
                trap_d.tval      = ls_exc.tval;
                trap_d.pc        = ls_exc.pc;
            end else if (accept && req.op == gc_pkg::OP_ECALL) begin
                // Machine mode only
                trap_d.take_trap = 1'b1;
                trap_d.code      = gc_pkg::EXC_ECALL_M;
                trap_d.pc        = req.pc;
            end else if (accept && req.op == gc_pkg::OP_EBREAK) begin
                trap_d.take_trap = 1'b1;
                trap_d.code      = gc_pkg::EXC_BREAK;
                trap_d.pc        = req.pc;
            end else if (accept && req.op == gc_pkg::OP_MRET) begin
                trap_d.mret = 1'b1;
            end
        end else if (csr_start && csr_illegal) begin
            // Unknown CSR address
            trap_d.take_trap = 1'b1;
            trap_d.code      = gc_pkg::EXC_ILLEGAL;
            trap_d.tval      = stage_q.instr;
            trap_d.pc        = stage_q.pc;
        end
    end

    // One-cycle pulse into the CSR file, lines up with FLUSH
    always_ff @(posedge clk) begin
        if (rst) begin
            trap_q <= '0;
        end else begin
            trap_q <= trap_d;
        end
    end

    assign trap = trap_q;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:      next_state = PRE_CLEAR;
            PRE_CLEAR:  next_state = INIT_CLEAR;
            INIT_CLEAR: if (clear_done) next_state = IDLE;
            IDLE: begin
                if (trap_d.take_trap || trap_d.mret) begin
                    next_state = FLUSH;
                end else if (accept) begin
                    // Only CSR ops and FENCE.I remain
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                if (ls_idle) begin
                    if (!stage_is_csr || csr_illegal) begin
                        next_state = FLUSH;
                    end else begin
                        next_state = WB_WAIT;
                    end
                end
            end
            FLUSH:      next_state = REDIRECT;
            REDIRECT:   next_state = IDLE;
            WB_WAIT:    if (wb_ready) next_state = IDLE;
            default:    next_state = RESET;
        endcase
    end

    // Clear phase timing
    assign clear_start = (state == PRE_CLEAR);
    assign init_clear  = (state == INIT_CLEAR);
    assign fetch_hold  = state inside {PRE_CLEAR, INIT_CLEAR};
    assign issue_hold  = state inside {PRE_CLEAR, INIT_CLEAR, DRAIN, FLUSH, REDIRECT, WB_WAIT};

    ////////////////////////////////////////////////////////////////////////////
    // Flush then redirect
    // Target picked during FLUSH, presented in REDIRECT
    always_ff @(posedge clk) begin
        if (state == FLUSH) begin
            if (trap_q.take_trap) begin
                redirect_pc_q <= mtvec;
            end else if (trap_q.mret) begin
                redirect_pc_q <= mepc;
            end else begin
                // FENCE.I resumes at the next instruction
                redirect_pc_q <= stage_q.pc + 32'd4;
            end
        end
    end

    assign fetch_flush    = (state == FLUSH);
    assign redirect_valid = (state == REDIRECT);
    assign redirect_pc    = redirect_pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // CSR access and write-back
    assign csr_start   = (state == DRAIN) & ls_idle & stage_is_csr;
    assign csr_op      = stage_q.op;
    assign csr_addr    = stage_q.csr_addr;
    assign csr_operand = stage_q.operand;

    // Old value captured at the RMW, held until accepted
    always_ff @(posedge clk) begin
        if (csr_start && !csr_illegal) begin
            wb_q.id   <= stage_q.id;
            wb_q.data <= csr_rdata;
        end
    end

    assign wb       = wb_q;
    assign wb_valid = (state == WB_WAIT);

endmodule
